/* aesDecrypt_settings.svh */
`ifndef AES_DECRYPT_SETTINGS_SVH
`define AES_DECRYPT_SETTINGS_SVH

`define AES_NB          16      // Bytes per block.
`define AES_NROWS       4       // Rows per state column.
`define AES_NROUNDS     10      // AES-128 round count.

// Cycles to wait for done before a run is declared hung.
`define AES_TB_TIMEOUT  100

`endif

/* aesDecrypt_pkg.sv */
`include "aesDecrypt_settings.svh"

package aesDecrypt_pkg;

    typedef logic [7:0]                   aesByte_t;
    typedef aesByte_t [`AES_NB-1:0]       aesBlock_t;     // Byte 0 is the first FIPS byte.
    typedef logic [31:0]                  aesWord_t;
    typedef logic [3:0]                   roundIdx_t;

    typedef enum logic [2:0]
    {
        IDLE,
        EXPAND,
        INITKEY,
        SUBSHIFT,
        ADDKEY,
        MIXCOL,
        FINISH
    } decState_t;

    ////////////////////
    // Entry 0 of each substitution table is leftmost.
    ////////////////////

    localparam aesByte_t [0:255] sbox = {
        128'h637c777bf26b6fc53001672bfed7ab76, 128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115, 128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84, 128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8, 128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973, 128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479, 128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a, 128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df, 128'h8ca1890dbfe6426841992d0fb054bb16
    };

    localparam aesByte_t [0:255] invSbox = {
        128'h52096ad53036a538bf40a39e81f3d7fb, 128'h7ce339829b2fff87348e4344c4dee9cb,
        128'h547b9432a6c2233dee4c950b42fac34e, 128'h082ea16628d924b2765ba2496d8bd125,
        128'h72f8f66486689816d4a45ccc5d65b692, 128'h6c704850fdedb9da5e154657a78d9d84,
        128'h90d8ab008cbcd30af7e45805b8b34506, 128'hd02c1e8fca3f0f02c1afbd0301138a6b,
        128'h3a9111414f67dcea97f2cfcef0b4e673, 128'h96ac7422e7ad3585e2f937e81c75df6e,
        128'h47f11a711d29c5896fb7620eaa18be1b, 128'hfc563e4bc6d279209adbc0fe78cd5af4,
        128'h1fdda8338807c731b11210592780ec5f, 128'h60517fa919b54a0d2de57a9f93c99cef,
        128'ha0e03b4dae2af5b0c8ebbb3c83539961, 128'h172b047eba77d626e169146355210c7d
    };

    // Multiply by x in GF(2^8) modulo x^8 + x^4 + x^3 + x + 1.
    function automatic aesByte_t xtime(input aesByte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

endpackage

/* mod_dec_keyExpand.sv */
`include "aesDecrypt_settings.svh"

module mod_dec_keyExpand
(
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      expandStart,
    input  aesDecrypt_pkg::aesBlock_t key,
    input  aesDecrypt_pkg::roundIdx_t keyIdx,
    output aesDecrypt_pkg::aesBlock_t roundKey,
    output logic                      expandDone
);
    import aesDecrypt_pkg::*;

    localparam roundIdx_t LAST_ROUND = roundIdx_t'(`AES_NROUNDS);

    aesBlock_t rkArray [0:`AES_NROUNDS];
    aesBlock_t lastKey;
    aesBlock_t nextKey;
    aesWord_t  rotWord;
    aesWord_t  subWord;
    aesWord_t  colWord;
    aesWord_t  chainWord;
    aesByte_t  rcon;
    roundIdx_t cnt;
    logic      running;

    ////////////////////
    // One AES-128 schedule step from the previous round key.
    ////////////////////
    always_comb
    begin
        rotWord = {lastKey[13], lastKey[14], lastKey[15], lastKey[12]};    // RotWord of w3.
        for (int b = 0; b < `AES_NROWS; b++)
            subWord[31-8*b -: 8] = sbox[rotWord[31-8*b -: 8]];
        chainWord = subWord ^ {rcon, 24'h000000};
        for (int c = 0; c < `AES_NROWS; c++)
        begin
            colWord = {lastKey[4*c], lastKey[4*c+1], lastKey[4*c+2], lastKey[4*c+3]};
            chainWord = chainWord ^ colWord;                                // w[i] = w[i-4] ^ w[i-1].
            for (int r = 0; r < `AES_NROWS; r++)
                nextKey[4*c+r] = chainWord[31-8*r -: 8];
        end
    end

    always_ff @(posedge clk)
    begin
        if (expandStart)
        begin
            rkArray[0] <= key;
            lastKey <= key;
        end
        else if (running)
        begin
            rkArray[cnt] <= nextKey;
            lastKey <= nextKey;
        end
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            running <= 1'b0;
            cnt <= '0;
            rcon <= '0;
        end
        else if (expandStart)
        begin
            running <= 1'b1;
            cnt <= 4'd1;
            rcon <= 8'h01;
        end
        else if (running)
        begin
            if (cnt == LAST_ROUND)
                running <= 1'b0;
            cnt <= cnt + 4'd1;
            rcon <= xtime(rcon);
        end
    end

    assign roundKey = rkArray[keyIdx];
    assign expandDone = running && (cnt == LAST_ROUND);    // Round key 10 lands on this edge.

    // The controller must not restart the schedule mid-expansion.
    assert property (@(posedge clk) disable iff (!resetn) expandStart |-> !running);

endmodule

/* mod_dec_invSubShift.sv */
`include "aesDecrypt_settings.svh"

module mod_dec_invSubShift
(
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      wr_en,
    input  aesDecrypt_pkg::aesBlock_t inp_sub,
    output aesDecrypt_pkg::aesBlock_t outp_sub
);
    import aesDecrypt_pkg::*;

    // Row r rotates right by r columns, then every byte goes through the inverse S-box.
    function automatic aesBlock_t invSubShift(input aesBlock_t blk);
        aesBlock_t res;
        int        src;
        for (int c = 0; c < `AES_NB / `AES_NROWS; c++)
        begin
            for (int r = 0; r < `AES_NROWS; r++)
            begin
                src = ((c - r + `AES_NROWS) % `AES_NROWS) * `AES_NROWS + r;
                res[c*`AES_NROWS + r] = invSbox[blk[src]];
            end
        end
        return res;
    endfunction

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            outp_sub <= '0;
        end
        else if (wr_en)
        begin
            outp_sub <= invSubShift(inp_sub);   // Held until the next strobe.
        end
    end

endmodule

/* mod_dec_mixColumns.sv */
`include "aesDecrypt_settings.svh"

module mod_dec_mixColumns
(
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      wr_en,
    input  aesDecrypt_pkg::aesBlock_t inp_mC,
    output aesDecrypt_pkg::aesBlock_t outp_mC
);
    import aesDecrypt_pkg::*;

    // InvMixColumns from FIPS 197, matrix rows {0e, 0b, 0d, 09} rotated per output row.
    function automatic aesBlock_t invMixColumns(input aesBlock_t blk);
        aesBlock_t                res;
        aesByte_t                 x2;
        aesByte_t                 x4;
        aesByte_t                 x8;
        aesByte_t [`AES_NROWS-1:0] m9;
        aesByte_t [`AES_NROWS-1:0] mB;
        aesByte_t [`AES_NROWS-1:0] mD;
        aesByte_t [`AES_NROWS-1:0] mE;
        for (int c = 0; c < `AES_NB / `AES_NROWS; c++)
        begin
            for (int r = 0; r < `AES_NROWS; r++)
            begin
                x2 = xtime(blk[c*`AES_NROWS + r]);
                x4 = xtime(x2);
                x8 = xtime(x4);
                m9[r] = x8 ^ blk[c*`AES_NROWS + r];
                mB[r] = x8 ^ x2 ^ blk[c*`AES_NROWS + r];
                mD[r] = x8 ^ x4 ^ blk[c*`AES_NROWS + r];
                mE[r] = x8 ^ x4 ^ x2;
            end
            for (int r = 0; r < `AES_NROWS; r++)
            begin
                res[c*`AES_NROWS + r] = mE[r] ^ mB[(r+1) % `AES_NROWS]
                                      ^ mD[(r+2) % `AES_NROWS] ^ m9[(r+3) % `AES_NROWS];
            end
        end
        return res;
    endfunction

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            outp_mC <= '0;
        end
        else if (wr_en)
        begin
            outp_mC <= invMixColumns(inp_mC);   // Captured once the key add is ready.
        end
    end

endmodule

/* mod_dec_control.sv */
`include "aesDecrypt_settings.svh"

module mod_dec_control
(
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      start,
    input  aesDecrypt_pkg::aesBlock_t cipherText,
    input  aesDecrypt_pkg::aesBlock_t subOut,
    input  aesDecrypt_pkg::aesBlock_t mcOut,
    input  aesDecrypt_pkg::aesBlock_t roundKey,
    input  logic                      expandDone,
    output logic                      expandStart,
    output aesDecrypt_pkg::roundIdx_t keyIdx,
    output logic                      subWr,
    output aesDecrypt_pkg::aesBlock_t subIn,
    output logic                      mcWr,
    output aesDecrypt_pkg::aesBlock_t mcIn,
    output aesDecrypt_pkg::aesBlock_t plainText,
    output logic                      busy,
    output logic                      done
);
    import aesDecrypt_pkg::*;

    decState_t curState;
    decState_t nextState;
    roundIdx_t roundCnt;
    aesBlock_t stateBlk;
    aesBlock_t addKeyBlk;
    aesBlock_t plainReg;

    ////////////////////
    // Round sequencing.
    ////////////////////
    always_comb
    begin
        nextState = curState;
        case (curState)
            IDLE:     if (start) nextState = EXPAND;
            EXPAND:   if (expandDone) nextState = INITKEY;
            INITKEY:  nextState = SUBSHIFT;
            SUBSHIFT: nextState = (roundCnt == '0) ? FINISH : ADDKEY;   // Last round skips the mix.
            ADDKEY:   nextState = MIXCOL;
            MIXCOL:   nextState = SUBSHIFT;
            FINISH:   nextState = IDLE;
            default:  nextState = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            curState <= IDLE;
            roundCnt <= '0;
            plainReg <= '0;
        end
        else
        begin
            curState <= nextState;
            if (curState == IDLE && start)
                roundCnt <= roundIdx_t'(`AES_NROUNDS);
            else if (curState == INITKEY || curState == MIXCOL)
                roundCnt <= roundCnt - 4'd1;
            if (curState == FINISH)
                plainReg <= addKeyBlk;
        end
    end

    // Cipher state register.
    always_ff @(posedge clk)
    begin
        case (curState)
            IDLE:    if (start) stateBlk <= cipherText;
            INITKEY: stateBlk <= stateBlk ^ roundKey;
            MIXCOL:  stateBlk <= mcOut;
            default: ;
        endcase
    end

    assign addKeyBlk = subOut ^ roundKey;
    assign expandStart = (curState == IDLE) && start;
    assign keyIdx = roundCnt;
    assign subWr = (curState == SUBSHIFT);
    assign subIn = stateBlk;
    assign mcWr = (curState == ADDKEY);
    assign mcIn = addKeyBlk;
    assign busy = (curState != IDLE);
    assign done = (curState == FINISH);
    assign plainText = done ? addKeyBlk : plainReg;     // Valid in the done cycle, held after.

    // A run ends with a single done 40 cycles after its start cycle.
    assert property (@(posedge clk) disable iff (!resetn)
                     done |-> $past(busy, 39) && !$past(busy, 40));

endmodule

/* aesDecryptTop.sv */
module aesDecryptTop
(
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      start,
    input  aesDecrypt_pkg::aesBlock_t cipherText,
    input  aesDecrypt_pkg::aesBlock_t key,
    output aesDecrypt_pkg::aesBlock_t plainText,
    output logic                      busy,
    output logic                      done
);
    import aesDecrypt_pkg::*;

    logic      expandStart;
    logic      expandDone;
    roundIdx_t keyIdx;
    aesBlock_t roundKey;
    logic      subWr;
    aesBlock_t subIn;
    aesBlock_t subOut;
    logic      mcWr;
    aesBlock_t mcIn;
    aesBlock_t mcOut;

    mod_dec_control uControl
    (
        .clk         (clk),
        .resetn      (resetn),
        .start       (start),
        .cipherText  (cipherText),
        .subOut      (subOut),
        .mcOut       (mcOut),
        .roundKey    (roundKey),
        .expandDone  (expandDone),
        .expandStart (expandStart),
        .keyIdx      (keyIdx),
        .subWr       (subWr),
        .subIn       (subIn),
        .mcWr        (mcWr),
        .mcIn        (mcIn),
        .plainText   (plainText),
        .busy        (busy),
        .done        (done)
    );

    mod_dec_keyExpand uKeyExpand
    (
        .clk         (clk),
        .resetn      (resetn),
        .expandStart (expandStart),
        .key         (key),
        .keyIdx      (keyIdx),
        .roundKey    (roundKey),
        .expandDone  (expandDone)
    );

    mod_dec_invSubShift uInvSubShift
    (
        .clk      (clk),
        .resetn   (resetn),
        .wr_en    (subWr),
        .inp_sub  (subIn),
        .outp_sub (subOut)
    );

    mod_dec_mixColumns uMixColumns
    (
        .clk     (clk),
        .resetn  (resetn),
        .wr_en   (mcWr),
        .inp_mC  (mcIn),
        .outp_mC (mcOut)
    );

endmodule

/* tb_aesDecrypt.sv */
`include "aesDecrypt_settings.svh"

module tb_aesDecrypt;
    timeunit 1ns;
    timeprecision 1ps;
    import aesDecrypt_pkg::*;

    logic      clk;
    logic      resetn;
    logic      start;
    aesBlock_t cipherText;
    aesBlock_t key;
    aesBlock_t plainText;
    logic      busy;
    logic      done;

    aesByte_t    sTab [0:255];
    aesByte_t    invTab [0:255];
    logic [31:0] rngState = 32'd93;
    int          checkCount = 0;
    int          errCount = 0;
    int          testMark = 0;

    aesDecryptTop UUT
    (
        .clk        (clk),
        .resetn     (resetn),
        .start      (start),
        .cipherText (cipherText),
        .key        (key),
        .plainText  (plainText),
        .busy       (busy),
        .done       (done)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////
    // Reference AES-128 inverse cipher.
    ////////////////////
    function automatic aesByte_t gfMul(input aesByte_t a, input aesByte_t b);
        aesByte_t p;
        aesByte_t aa;
        aesByte_t bb;
        p = 8'h00;
        aa = a;
        bb = b;
        for (int i = 0; i < 8; i++)
        begin
            if (bb[0])
                p = p ^ aa;
            aa = {aa[6:0], 1'b0} ^ (aa[7] ? 8'h1b : 8'h00);
            bb = bb >> 1;
        end
        return p;
    endfunction

    function automatic aesByte_t rotl8(input aesByte_t b, input int n);
        return aesByte_t'({b, b} >> (8 - n));
    endfunction

    // S-box as affine map of the field inverse.
    task automatic buildSbox();
        aesByte_t inv;
        aesByte_t s;
        for (int x = 0; x < 256; x++)
        begin
            inv = 8'h00;
            for (int y = 1; y < 256; y++)
                if (x != 0 && gfMul(aesByte_t'(x), aesByte_t'(y)) == 8'h01)
                    inv = aesByte_t'(y);
            s = inv ^ rotl8(inv, 1) ^ rotl8(inv, 2) ^ rotl8(inv, 3) ^ rotl8(inv, 4) ^ 8'h63;
            sTab[x] = s;
            invTab[s] = aesByte_t'(x);
        end
    endtask

    function automatic aesBlock_t invRound(input aesBlock_t st);
        aesBlock_t res;
        for (int c = 0; c < 4; c++)
            for (int r = 0; r < 4; r++)
                res[((c + r) % 4) * 4 + r] = invTab[st[c*4 + r]];  // Row r moves right by r.
        return res;
    endfunction

    function automatic aesBlock_t invMix(input aesBlock_t st);
        aesBlock_t res;
        aesByte_t  a [0:3];
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
                a[r] = st[c*4 + r];
            res[c*4]   = gfMul(a[0], 8'h0e) ^ gfMul(a[1], 8'h0b)
                       ^ gfMul(a[2], 8'h0d) ^ gfMul(a[3], 8'h09);
            res[c*4+1] = gfMul(a[0], 8'h09) ^ gfMul(a[1], 8'h0e)
                       ^ gfMul(a[2], 8'h0b) ^ gfMul(a[3], 8'h0d);
            res[c*4+2] = gfMul(a[0], 8'h0d) ^ gfMul(a[1], 8'h09)
                       ^ gfMul(a[2], 8'h0e) ^ gfMul(a[3], 8'h0b);
            res[c*4+3] = gfMul(a[0], 8'h0b) ^ gfMul(a[1], 8'h0d)
                       ^ gfMul(a[2], 8'h09) ^ gfMul(a[3], 8'h0e);
        end
        return res;
    endfunction

    function automatic aesBlock_t modelDecrypt(input aesBlock_t ct, input aesBlock_t k);
        aesWord_t  w [0:43];
        aesBlock_t rk [0:10];
        aesBlock_t st;
        aesWord_t  t;
        aesByte_t  rc;
        for (int c = 0; c < 4; c++)
            w[c] = {k[4*c], k[4*c+1], k[4*c+2], k[4*c+3]};
        rc = 8'h01;
        for (int i = 4; i < 44; i++)
        begin
            t = w[i-1];
            if (i % 4 == 0)
            begin
                t = {t[23:0], t[31:24]};
                t = {sTab[t[31:24]] ^ rc, sTab[t[23:16]], sTab[t[15:8]], sTab[t[7:0]]};
                rc = gfMul(rc, 8'h02);
            end
            w[i] = w[i-4] ^ t;
        end
        for (int r = 0; r < 11; r++)
            for (int c = 0; c < 4; c++)
                for (int j = 0; j < 4; j++)
                    rk[r][4*c + j] = w[4*r + c][31-8*j -: 8];
        st = ct ^ rk[10];
        for (int rnd = 9; rnd >= 1; rnd--)
            st = invMix(invRound(st) ^ rk[rnd]);
        return invRound(st) ^ rk[0];
    endfunction

    ////////////////////
    // Helpers and checks.
    ////////////////////
    function automatic aesBlock_t fromHex(input logic [127:0] h);
        aesBlock_t b;
        for (int i = 0; i < 16; i++)
            b[i] = h[127-8*i -: 8];     // First FIPS byte is leftmost.
        return b;
    endfunction

    function automatic logic [127:0] toHex(input aesBlock_t b);
        logic [127:0] h;
        for (int i = 0; i < 16; i++)
            h[127-8*i -: 8] = b[i];
        return h;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    task automatic randomBlock(output aesBlock_t blk);
        for (int i = 0; i < 4; i++)
        begin
            rngState = xorshift32(rngState);
            blk[4*i +: 4] = rngState;
        end
    endtask

    task automatic compareBlock(input string what, input aesBlock_t got, input aesBlock_t exp);
        checkCount++;
        if (got !== exp)
        begin
            errCount++;
            $display("ERR %0t: %s got %032h expected %032h", $time, what, toHex(got), toHex(exp));
        end
    endtask

    task automatic compareFlag(input string what, input logic got, input logic exp);
        checkCount++;
        if (got !== exp)
        begin
            errCount++;
            $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic compareCount(input string what, input int got, input int exp);
        checkCount++;
        if (got != exp)
        begin
            errCount++;
            $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic reportTest(input string name);
        if (errCount == testMark)
            $display("test %s: ok", name);
        else
            $display("test %s: FAIL with %0d errors", name, errCount - testMark);
        testMark = errCount;
    endtask

    task automatic launch(input aesBlock_t ct, input aesBlock_t k);
        @(posedge clk);
        start <= 1'b1;
        cipherText <= ct;
        key <= k;
        @(negedge clk);
        compareFlag("busy in start cycle", busy, 1'b0);
        @(posedge clk);
        start <= 1'b0;
    endtask

    // Counts cycles after the start cycle; may drive a second start pulse mid-run.
    task automatic waitDone(input int injectAt, input aesBlock_t injCt, input aesBlock_t injKey,
                            output int cycles);
        logic seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < `AES_TB_TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
            compareFlag("busy during run", busy, 1'b1);
            if (done)
                seen = 1'b1;
            else if (cycles == injectAt)
            begin
                @(posedge clk);
                start <= 1'b1;
                cipherText <= injCt;
                key <= injKey;
            end
            else if (injectAt != 0 && cycles == injectAt + 1)
            begin
                @(posedge clk);
                start <= 1'b0;
            end
        end
        if (!seen)
        begin
            errCount++;
            $display("Timeout: done did not arrive within %0d cycles of start", cycles);
        end
    endtask

    task automatic runAndCheck(input aesBlock_t ct, input aesBlock_t k, input aesBlock_t exp);
        int lat;
        launch(ct, k);
        waitDone(0, ct, k, lat);
        compareCount("done latency", lat, 40);
        compareBlock("plainText at done", plainText, exp);
        @(negedge clk);
        compareFlag("done after pulse", done, 1'b0);
        compareBlock("plainText held", plainText, exp);
    endtask

    ////////////////////
    // Test sequence.
    ////////////////////
    initial
    begin
        aesBlock_t ct;
        aesBlock_t k;
        aesBlock_t ct2;
        aesBlock_t k2;
        aesBlock_t exp;
        int        lat;
        resetn = 1'b0;
        start = 1'b0;
        cipherText = '0;
        key = '0;
        buildSbox();
        repeat (16) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);

        compareFlag("busy after reset", busy, 1'b0);
        compareFlag("done after reset", done, 1'b0);
        compareBlock("plainText after reset", plainText, '0);
        reportTest("reset state");

        ct = fromHex(128'h69c4e0d86a7b0430d8cdb78070b4c55a);
        k = fromHex(128'h000102030405060708090a0b0c0d0e0f);
        exp = fromHex(128'h00112233445566778899aabbccddeeff);
        compareBlock("model on FIPS vector", modelDecrypt(ct, k), exp);
        runAndCheck(ct, k, exp);
        reportTest("FIPS 197 C.1 vector");

        for (int n = 0; n < 40; n++)
        begin
            randomBlock(ct);
            randomBlock(k);
            runAndCheck(ct, k, modelDecrypt(ct, k));
        end
        reportTest("random pairs");

        randomBlock(ct);
        randomBlock(k);
        randomBlock(ct2);
        randomBlock(k2);
        launch(ct, k);
        waitDone(5, ct2, k2, lat);     // Second pulse lands while busy.
        compareCount("latency with ignored start", lat, 40);
        compareBlock("first run result", plainText, modelDecrypt(ct, k));
        for (int n = 0; n < 50; n++)
        begin
            @(negedge clk);
            compareFlag("second done pulse", done, 1'b0);
            compareFlag("busy after run", busy, 1'b0);
        end
        compareBlock("result after idle", plainText, modelDecrypt(ct, k));
        reportTest("start while busy");

        randomBlock(ct);
        for (int n = 0; n < 5; n++)
        begin
            randomBlock(k);
            runAndCheck(ct, k, modelDecrypt(ct, k));    // Same data, fresh key each run.
        end
        reportTest("back-to-back new keys");

        randomBlock(ct);
        randomBlock(k);
        launch(ct, k);
        repeat (15) @(negedge clk);
        compareFlag("busy before reset", busy, 1'b1);
        @(posedge clk);
        resetn <= 1'b0;
        for (int n = 0; n < 4; n++)
        begin
            @(negedge clk);
            compareFlag("busy in reset", busy, 1'b0);
            compareFlag("done in reset", done, 1'b0);
        end
        @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        compareFlag("done after mid-run reset", done, 1'b0);
        randomBlock(ct);
        randomBlock(k);
        runAndCheck(ct, k, modelDecrypt(ct, k));
        reportTest("reset mid-run");

        $display("%0d checks, %0d errors", checkCount, errCount);
        if (errCount == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

/* aesDecrypt.f */
+incdir+.
aesDecrypt_pkg.sv
mod_dec_keyExpand.sv
mod_dec_invSubShift.sv
mod_dec_mixColumns.sv
mod_dec_control.sv
aesDecryptTop.sv
tb_aesDecrypt.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f aesDecrypt.f \
    --top-module tb_aesDecrypt -o simAesDecrypt

out=$(./obj_dir/simAesDecrypt 2>&1) || true
echo "$out"

if echo "$out" | grep -q "All checks passed"; then
    exit 0
fi
exit 1
